// File: sources.f
design/mips_exec_pkg.sv
design/alu_decoder.sv
design/alu.sv
design/mul_div_unit.sv
design/exec_stage.sv
tests/tb_exec_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage
    import mips_exec_pkg::*;
();

    localparam int clk_period  = 100;
    localparam int n_instr     = 299;                      // Instructions issued over all tests
    localparam int stall_limit = 2 * div_cycles + 8;       // Far beyond one divide
    localparam longint watchdog_ns = (longint'(n_instr) * 40 + 8) * clk_period;

    logic                  clk;
    logic                  rst_n;
    logic                  valid;
    logic [31:0]           instr;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] result;
    logic                  result_valid;
    logic                  branch_taken;
    logic                  zero;
    logic                  stall;

    int                    errors;
    int                    checks;
    logic [31:0]           exp_hi;                         // Model HI/LO
    logic [31:0]           exp_lo;

    exec_stage dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .instr        (instr),
        .a            (a),
        .b            (b),
        .result       (result),
        .result_valid (result_valid),
        .branch_taken (branch_taken),
        .zero         (zero),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, expv);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("ERR %0t ns: %s got %b expected %b", $time, what, got, expv);
        end
    endtask

    task automatic check_op(input string what, input alu_op_t got, input alu_op_t expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("ERR %0t ns: %s got %s expected %s", $time, what, got.name(), expv.name());
        end
    endtask

    // Instruction word from the field codes with rs=1 rt=2 rd=3
    function automatic logic [31:0] encode(input alu_op_t op, input logic [4:0] sh,
                                           input logic [15:0] imm);
        logic [5:0] fn;
        fn = 6'h3f;                                        // Unused funct
        case (op)
            op_beq:  return {opc_beq, 5'd1, 5'd2, imm};
            op_bne:  return {opc_bne, 5'd1, 5'd2, imm};
            op_blez: return {opc_blez, 5'd1, 5'd0, imm};
            op_bgtz: return {opc_bgtz, 5'd1, 5'd0, imm};
            op_bltz: return {opc_regimm, 5'd1, rt_bltz, imm};
            op_bgez: return {opc_regimm, 5'd1, rt_bgez, imm};
            op_lui:  return {opc_lui, 5'd0, 5'd2, imm};
            op_and:   fn = fn_and;
            op_or:    fn = fn_or;
            op_xor:   fn = fn_xor;
            op_addu:  fn = fn_addu;
            op_subu:  fn = fn_subu;
            op_slt:   fn = fn_slt;
            op_sltu:  fn = fn_sltu;
            op_sll:   fn = fn_sll;
            op_srl:   fn = fn_srl;
            op_sra:   fn = fn_sra;
            op_sllv:  fn = fn_sllv;
            op_srlv:  fn = fn_srlv;
            op_srav:  fn = fn_srav;
            op_pass_a: fn = fn_jr;
            op_mfhi:  fn = fn_mfhi;
            op_mflo:  fn = fn_mflo;
            op_mult:  fn = fn_mult;
            op_multu: fn = fn_multu;
            op_div:   fn = fn_div;
            op_divu:  fn = fn_divu;
            default:  fn = 6'h3f;
        endcase
        return {opc_special, 5'd1, 5'd2, 5'd3, sh, fn};
    endfunction

    // Arithmetic right shift one bit at a time
    function automatic logic [31:0] sra_ref(input logic [31:0] v, input logic [4:0] n);
        logic [31:0] r;
        r = v;
        for (int i = 0; i < 32'(n); i++) begin
            r = {r[31], r[31:1]};
        end
        return r;
    endfunction

    function automatic logic [31:0] model_y(input alu_op_t op, input logic [31:0] x,
                                            input logic [31:0] z, input logic [4:0] sh);
        logic [31:0] r;
        r = 32'h0;
        case (op)
            op_and:    r = x & z;
            op_or:     r = x | z;
            op_xor:    r = x ^ z;
            op_addu:   r = x + z;
            op_subu:   r = x - z;
            op_slt:    r[0] = ($signed(x) < $signed(z));
            op_sltu:   r[0] = (x < z);
            op_sll:    r = z << sh;
            op_srl:    r = z >> sh;
            op_sra:    r = sra_ref(z, sh);
            op_sllv:   r = z << x[4:0];                    // Amount from rs
            op_srlv:   r = z >> x[4:0];
            op_srav:   r = sra_ref(z, x[4:0]);
            op_lui:    r = {z[15:0], 16'h0000};
            op_pass_a: r = x;
            op_mfhi:   r = exp_hi;
            op_mflo:   r = exp_lo;
            op_beq:    r[0] = (x == z);                    // Taken flag
            op_bne:    r[0] = (x != z);
            op_blez:   r[0] = ($signed(x) <= 32'sd0);
            op_bgtz:   r[0] = ($signed(x) > 32'sd0);
            op_bltz:   r[0] = ($signed(x) < 32'sd0);
            op_bgez:   r[0] = ($signed(x) >= 32'sd0);
            default:   r = 32'h0;
        endcase
        return r;
    endfunction

    function automatic logic writes_gpr(input alu_op_t op);
        return !(op inside {op_beq, op_bne, op_blez, op_bgtz, op_bltz, op_bgez,
                            op_mult, op_multu, op_div, op_divu, op_nop});
    endfunction

    function automatic logic is_branch(input alu_op_t op);
        return op inside {op_beq, op_bne, op_blez, op_bgtz, op_bltz, op_bgez};
    endfunction

    // HI/LO after a multiply or divide
    task automatic update_hilo(input alu_op_t op, input logic [31:0] ra, input logic [31:0] rb);
        logic [63:0] p;
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] qm;
        logic [31:0] rm;
        logic        sa;
        logic        sb;
        sa = (op == op_div) && ra[31];
        sb = (op == op_div) && rb[31];
        am = sa ? -ra : ra;
        bm = sb ? -rb : rb;
        if (bm == 32'h0) begin
            qm = '1;                                       // Divide by zero
            rm = am;
        end else begin
            qm = am / bm;
            rm = am % bm;
        end
        case (op)
            op_mult: begin
                p = 64'(longint'($signed(ra)) * longint'($signed(rb)));
                {exp_hi, exp_lo} = p;
            end
            op_multu: begin
                p = {32'h0, ra} * {32'h0, rb};
                {exp_hi, exp_lo} = p;
            end
            op_div, op_divu: begin
                exp_hi = sa ? -rm : rm;                    // Sign of dividend
                exp_lo = (sa ^ sb) ? -qm : qm;             // Toward zero
            end
            default: ;
        endcase
    endtask

    // Called just after a rising edge and returns just after the accepting edge
    task automatic issue(input alu_op_t op, input logic [31:0] ra, input logic [31:0] rb,
                         input logic [4:0] sh, output int stalls);
        stalls = 0;
        valid <= 1'b1;
        instr <= encode(op, sh, (op == op_lui) ? rb[15:0] : 16'h0010);
        a     <= ra;
        b     <= rb;
        @(negedge clk);
        while (stall && stalls < stall_limit) begin
            stalls++;
            @(negedge clk);
        end
        if (stall) begin
            errors++;
            $display("stall stayed high for %0d cycles, %s was never accepted",
                     stalls, op.name());
        end
        check_op("decoded op", dut0.alu_op, op);
        @(posedge clk);                                    // Accepting edge
    endtask

    // Drop valid and check the registered outputs of the last accepted op
    task automatic complete(input alu_op_t op, input logic [31:0] ra, input logic [31:0] rb,
                            input logic [4:0] sh);
        logic [31:0] exp_y;
        valid <= 1'b0;
        @(negedge clk);
        exp_y = model_y(op, ra, rb, sh);
        check_bit($sformatf("%s result_valid", op.name()), result_valid, writes_gpr(op));
        check_bit($sformatf("%s branch_taken", op.name()), branch_taken,
                  is_branch(op) && exp_y[0]);
        if (writes_gpr(op)) begin
            check_word($sformatf("%s result", op.name()), result, exp_y);
        end
        if (writes_gpr(op) || is_branch(op)) begin
            check_bit($sformatf("%s zero", op.name()), zero, exp_y == 32'h0);
        end
        @(posedge clk);
    endtask

    task automatic exec_op(input alu_op_t op, input logic [31:0] ra, input logic [31:0] rb,
                           input logic [4:0] sh);
        int stalls;
        issue(op, ra, rb, sh, stalls);
        update_hilo(op, ra, rb);
        complete(op, ra, rb, sh);
    endtask

    function automatic logic [31:0] corner(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;                 // Largest positive
            3:       return 32'h8000_0000;                 // Most negative
            4:       return 32'hffff_ffff;
            default: return 32'h1234_5678;
        endcase
    endfunction

    task automatic test_reset();
        @(negedge clk);
        check_bit("reset result_valid", result_valid, 1'b0);
        check_bit("reset branch_taken", branch_taken, 1'b0);
        check_bit("reset stall", stall, 1'b0);
        @(posedge clk);
        exec_op(op_mfhi, 32'h0, 32'h0, 5'd0);              // HI/LO cleared
        exec_op(op_mflo, 32'h0, 32'h0, 5'd0);
    endtask

    task automatic test_alu_ops();
        alu_op_t ops [9];
        ops = '{op_and, op_or, op_xor, op_addu, op_subu, op_slt, op_sltu, op_lui, op_pass_a};
        for (int k = 0; k < 9; k++) begin
            for (int i = 0; i < 6; i++) begin
                exec_op(ops[k], corner(i), corner(5 - i), 5'd0);
                exec_op(ops[k], corner(i), corner(i), 5'd0);   // Equal operands
            end
            for (int i = 0; i < 3; i++) begin
                exec_op(ops[k], $urandom(), $urandom(), 5'd0);
            end
        end
    endtask

    task automatic test_shifts();
        logic [31:0] vals [2];
        logic [4:0]  amts [4];
        logic [31:0] rnd;
        vals = '{32'h8000_0001, 32'h7fff_fff0};            // Negative and positive
        amts = '{5'd0, 5'd1, 5'd15, 5'd31};
        for (int v = 0; v < 2; v++) begin
            for (int j = 0; j < 4; j++) begin
                rnd = $urandom();
                exec_op(op_sll, rnd, vals[v], amts[j]);
                exec_op(op_srl, rnd, vals[v], amts[j]);
                exec_op(op_sra, rnd, vals[v], amts[j]);
                exec_op(op_sllv, {rnd[31:5], amts[j]}, vals[v], rnd[10:6]);
                exec_op(op_srlv, {rnd[31:5], amts[j]}, vals[v], rnd[10:6]);
                exec_op(op_srav, {rnd[31:5], amts[j]}, vals[v], rnd[10:6]);
            end
        end
    endtask

    task automatic test_mult();
        alu_op_t     mops [2];
        logic [31:0] xa [6];
        logic [31:0] xb [6];
        int          stalls;
        mops = '{op_mult, op_multu};
        xa = '{$urandom(), 32'hffff_fffd, 32'd7, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
        xb = '{$urandom(), 32'd7, 32'hffff_fffd, 32'h8000_0000, 32'hffff_ffff, 32'd2};
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 6; i++) begin
                issue(mops[s], xa[i], xb[i], 5'd0, stalls);
                update_hilo(mops[s], xa[i], xb[i]);
                exec_op(op_mfhi, 32'h0, 32'h0, 5'd0);      // Next cycle after the multiply
                exec_op(op_mflo, 32'h0, 32'h0, 5'd0);
            end
        end
    endtask

    task automatic test_div();
        alu_op_t     dops [2];
        logic [31:0] xa [7];
        logic [31:0] xb [7];
        int          stalls;
        dops = '{op_div, op_divu};
        // 100/7 in all sign combinations and then divide by zero
        xa = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'd5, 32'hffff_fffb, $urandom()};
        xb = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'd0, 32'd0, $urandom() | 32'd1};
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 7; i++) begin
                issue(dops[s], xa[i], xb[i], 5'd0, stalls);
                update_hilo(dops[s], xa[i], xb[i]);
                issue(op_mfhi, 32'h0, 32'h0, 5'd0, stalls);    // Held by stall
                check_word("divide stall cycles", 32'(stalls), 32'(div_cycles + 1));
                complete(op_mfhi, 32'h0, 32'h0, 5'd0);
                exec_op(op_mflo, 32'h0, 32'h0, 5'd0);
            end
        end
    endtask

    task automatic test_branches();
        alu_op_t     ops [6];
        logic [31:0] xa [6];
        logic [31:0] xb [6];
        ops = '{op_beq, op_bne, op_blez, op_bgtz, op_bltz, op_bgez};
        xa  = '{32'd0, 32'd5, 32'd5, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        xb  = '{32'd0, 32'd5, 32'd6, 32'd0, 32'd1, 32'd0};
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 6; i++) begin
                exec_op(ops[k], xa[i], xb[i], 5'd0);
            end
        end
    endtask

    // Ends a run that hangs
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, run stopped", watchdog_ns);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h3243));                         // Fixed seed
        errors   = 0;
        checks   = 0;
        exp_hi   = 32'h0;
        exp_lo   = 32'h0;
        rst_n    = 1'b0;
        valid    = 1'b0;
        instr    = 32'h0;
        a        = 32'h0;
        b        = 32'h0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_alu_ops();
        test_shifts();
        test_mult();
        test_div();
        test_branches();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import mips_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  logic [31:0]           instr,
    input  logic [data_width-1:0] a,                       // rs value
    input  logic [data_width-1:0] b,                       // rt or extended immediate
    output logic [data_width-1:0] result,
    output logic                  result_valid,
    output logic                  branch_taken,
    output logic                  zero,
    output logic                  stall
);

    alu_op_t               alu_op;
    op_class_t             op_class;
    logic [data_width-1:0] y;
    logic [data_width-1:0] hi;
    logic [data_width-1:0] lo;
    logic [data_width-1:0] res_next;
    logic                  alu_zero;
    logic                  accept;
    logic                  md_start;
    logic                  busy;

    assign stall    = busy;                                // Only the divider stalls
    assign accept   = valid && !busy;
    assign md_start = accept && (op_class == cls_muldiv);

    alu_decoder u_dec (
        .instr    (instr),
        .alu_op   (alu_op),
        .op_class (op_class)
    );

    alu u_alu (
        .alu_op (alu_op),
        .a      (a),
        .b      (b),
        .shamt  (instr[10:6]),                             // shamt field
        .y      (y),
        .zero   (alu_zero)
    );

    mul_div_unit u_md (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (md_start),
        .alu_op (alu_op),
        .a      (a),
        .b      (b),
        .hi     (hi),
        .lo     (lo),
        .busy   (busy)
    );

    // Result select
    always_comb begin
        case (alu_op)
            op_mfhi: res_next = hi;
            op_mflo: res_next = lo;
            default: res_next = y;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            result_valid <= accept && (op_class inside {cls_alu, cls_move});
            branch_taken <= accept && (op_class == cls_branch) && y[0];
        end
    end

    // Result and flag follow each accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            result <= res_next;
            if (op_class == cls_move) begin
                zero <= (res_next == '0);                  // ALU flag does not see HI/LO
            end else begin
                zero <= alu_zero;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_div_unit
    import mips_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  alu_op_t               alu_op,
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    output logic [data_width-1:0] hi,
    output logic [data_width-1:0] lo,
    output logic                  busy
);

    md_state_t                  state;
    logic [div_cnt_width-1:0]   count;                     // Iterations done
    logic [data_width-1:0]      rem;                       // Partial remainder
    logic [data_width-1:0]      quot;                      // Dividend in, quotient out
    logic [data_width-1:0]      divisor;
    logic                       neg_quot;
    logic                       neg_rem;
    logic                       is_mult;
    logic                       is_div;
    logic                       signed_op;
    logic [2*data_width-1:0]    ext_a;
    logic [2*data_width-1:0]    ext_b;
    logic [2*data_width-1:0]    product;
    logic [data_width-1:0]      a_mag;
    logic [data_width-1:0]      b_mag;
    logic [data_width:0]        rem_shift;
    logic [data_width:0]        diff;

    assign is_mult   = alu_op inside {op_mult, op_multu};
    assign is_div    = alu_op inside {op_div, op_divu};
    assign signed_op = alu_op inside {op_mult, op_div};

    // Sign or zero extend to 64 bits for the full product
    assign ext_a   = {{data_width{signed_op & a[data_width-1]}}, a};
    assign ext_b   = {{data_width{signed_op & b[data_width-1]}}, b};
    assign product = ext_a * ext_b;

    assign a_mag = (signed_op && a[data_width-1]) ? -a : a;
    assign b_mag = (signed_op && b[data_width-1]) ? -b : b;

    // Restoring step
    assign rem_shift = {rem, quot[data_width-1]};          // Bring down next dividend bit
    assign diff      = rem_shift - {1'b0, divisor};        // Bit 32 set means borrow

    assign busy = (state != md_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= md_idle;
            count <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                md_idle: begin
                    if (start && is_mult) begin
                        hi <= product[2*data_width-1:data_width];
                        lo <= product[data_width-1:0];
                    end else if (start && is_div) begin
                        state <= md_divide;
                        count <= '0;
                    end
                end
                md_divide: begin
                    count <= count + 1'b1;
                    if (count == div_cnt_width'(div_cycles - 1)) begin
                        state <= md_fixup;                 // Last quotient bit this edge
                    end
                end
                md_fixup: begin
                    hi    <= neg_rem ? -rem : rem;         // Remainder follows dividend
                    lo    <= neg_quot ? -quot : quot;
                    state <= md_idle;
                end
                default: state <= md_idle;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == md_idle && start && is_div) begin
            rem      <= '0;
            quot     <= a_mag;
            divisor  <= b_mag;
            neg_quot <= signed_op & (a[data_width-1] ^ b[data_width-1]);
            neg_rem  <= signed_op & a[data_width-1];
        end else if (state == md_divide) begin
            if (diff[data_width]) begin
                rem <= rem_shift[data_width-1:0];          // Restore
            end else begin
                rem <= diff[data_width-1:0];
            end
            quot <= {quot[data_width-2:0], ~diff[data_width]};
        end
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    ) else $error("mul_div_unit: start while busy");

    // Divide holds busy for all iterations plus the sign fixup
    a_div_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && is_div) |=> busy [*div_cycles + 1] ##1 !busy
    ) else $error("mul_div_unit: divide length wrong");

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import mips_exec_pkg::*;
(
    input  alu_op_t                alu_op,
    input  logic [data_width-1:0]  a,
    input  logic [data_width-1:0]  b,
    input  logic [shamt_width-1:0] shamt,
    output logic [data_width-1:0]  y,
    output logic                   zero
);

    logic [shamt_width-1:0] var_amt;
    logic                   a_neg;
    logic                   b_neg;
    logic                   a_is_zero;

    assign var_amt   = a[shamt_width-1:0];                 // Variable shifts take rs[4:0]
    assign a_neg     = a[data_width-1];
    assign b_neg     = b[data_width-1];
    assign a_is_zero = (a == '0);

    always_comb begin
        y = '0;                                            // Flags and HI/LO ops leave zero
        case (alu_op)
            op_and:    y = a & b;
            op_or:     y = a | b;
            op_xor:    y = a ^ b;
            op_addu:   y = a + b;
            op_subu:   y = a - b;
            op_sltu:   y[0] = (a < b);
            op_slt: begin
                if (a_neg != b_neg) begin
                    y[0] = a_neg;                          // Negative one is less when signs differ
                end else begin
                    y[0] = (a < b);                        // Raw compare holds for equal signs
                end
            end
            op_sll:    y = b << shamt;
            op_sllv:   y = b << var_amt;
            op_sra:    y = $signed(b) >>> shamt;           // Sign fill
            op_srav:   y = $signed(b) >>> var_amt;
            op_srl:    y = b >> shamt;
            op_srlv:   y = b >> var_amt;
            op_lui:    y = {b[15:0], 16'h0000};            // Immediate to upper half
            op_pass_a: y = a;                              // JR target
            op_beq:    y[0] = (a == b);
            op_bne:    y[0] = (a != b);
            op_blez:   y[0] = a_neg | a_is_zero;
            op_bgtz:   y[0] = !a_neg && !a_is_zero;
            op_bltz:   y[0] = a_neg;
            op_bgez:   y[0] = !a_neg;
            default:   y = '0;                             // Mul/div, moves, nop
        endcase
    end

    assign zero = (y == '0);

    // A defined operation must give a fully known result
    always_comb begin
        if (!$isunknown(alu_op)) begin
            assert (!$isunknown(y))
                else $error("alu: unknown result for op %s", alu_op.name());
        end
    end

endmodule

`default_nettype wire

// File: design/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
    import mips_exec_pkg::*;
(
    input  logic [31:0] instr,
    output alu_op_t     alu_op,
    output op_class_t   op_class
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];                          // REGIMM sub-opcode
    assign funct  = instr[5:0];

    always_comb begin
        alu_op = op_nop;                                   // Unknown encodings fall out as nop
        case (opcode)
            opc_special: begin
                case (funct)
                    fn_sll:   alu_op = op_sll;
                    fn_srl:   alu_op = op_srl;
                    fn_sra:   alu_op = op_sra;
                    fn_sllv:  alu_op = op_sllv;
                    fn_srlv:  alu_op = op_srlv;
                    fn_srav:  alu_op = op_srav;
                    fn_jr:    alu_op = op_pass_a;          // Target comes from rs
                    fn_mfhi:  alu_op = op_mfhi;
                    fn_mflo:  alu_op = op_mflo;
                    fn_mult:  alu_op = op_mult;
                    fn_multu: alu_op = op_multu;
                    fn_div:   alu_op = op_div;
                    fn_divu:  alu_op = op_divu;
                    fn_addu:  alu_op = op_addu;
                    fn_subu:  alu_op = op_subu;
                    fn_and:   alu_op = op_and;
                    fn_or:    alu_op = op_or;
                    fn_xor:   alu_op = op_xor;
                    fn_slt:   alu_op = op_slt;
                    fn_sltu:  alu_op = op_sltu;
                    default:  alu_op = op_nop;
                endcase
            end
            opc_regimm: begin
                case (rt)
                    rt_bltz: alu_op = op_bltz;
                    rt_bgez: alu_op = op_bgez;
                    default: alu_op = op_nop;              // Link forms not handled
                endcase
            end
            opc_beq:  alu_op = op_beq;
            opc_bne:  alu_op = op_bne;
            opc_blez: alu_op = op_blez;
            opc_bgtz: alu_op = op_bgtz;
            opc_lui:  alu_op = op_lui;
            default:  alu_op = op_nop;
        endcase
    end

    // Owner of each operation
    always_comb begin
        case (alu_op)
            op_beq, op_bne, op_blez, op_bgtz, op_bltz, op_bgez:
                op_class = cls_branch;
            op_mult, op_multu, op_div, op_divu:
                op_class = cls_muldiv;
            op_mfhi, op_mflo:
                op_class = cls_move;
            op_nop:
                op_class = cls_none;
            default:
                op_class = cls_alu;
        endcase
    end

endmodule

`default_nettype wire

// File: design/mips_exec_pkg.sv
`default_nettype none

package mips_exec_pkg;

    localparam int data_width    = 32;                    // Operand and result width
    localparam int shamt_width   = 5;                     // instr[10:6]
    localparam int div_cycles    = 32;                    // One quotient bit per iteration
    localparam int div_cnt_width = $clog2(div_cycles);    // Iteration counter width

    // Primary opcode field, instr[31:26]
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_regimm  = 6'h01;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_blez    = 6'h06;
    localparam logic [5:0] opc_bgtz    = 6'h07;
    localparam logic [5:0] opc_lui     = 6'h0f;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_sra   = 6'h03;
    localparam logic [5:0] fn_sllv  = 6'h04;
    localparam logic [5:0] fn_srlv  = 6'h06;
    localparam logic [5:0] fn_srav  = 6'h07;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_mfhi  = 6'h10;
    localparam logic [5:0] fn_mflo  = 6'h12;
    localparam logic [5:0] fn_mult  = 6'h18;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_div   = 6'h1a;
    localparam logic [5:0] fn_divu  = 6'h1b;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam logic [5:0] fn_sltu  = 6'h2b;

    // REGIMM rt field, instr[20:16]
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    // ALU control codes in a 5-bit field
    typedef enum logic [4:0] {
        op_and    = 5'd0,
        op_or     = 5'd1,
        op_xor    = 5'd2,
        op_addu   = 5'd3,
        op_subu   = 5'd4,
        op_sltu   = 5'd5,
        op_slt    = 5'd6,
        op_multu  = 5'd7,
        op_mult   = 5'd8,
        op_sll    = 5'd9,
        op_sllv   = 5'd10,
        op_sra    = 5'd11,
        op_srl    = 5'd12,
        op_srav   = 5'd13,
        op_srlv   = 5'd14,
        op_div    = 5'd15,
        op_divu   = 5'd16,
        op_mfhi   = 5'd17,
        op_mflo   = 5'd18,
        op_bltz   = 5'd19,
        op_bgtz   = 5'd20,
        op_bgez   = 5'd21,
        op_bne    = 5'd22,
        op_blez   = 5'd23,
        op_pass_a = 5'd24,
        op_lui    = 5'd25,
        op_beq    = 5'd26,
        op_nop    = 5'd27
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_alu,                                          // Writes y to a GPR
        cls_branch,                                       // y[0] is the taken flag
        cls_muldiv,                                       // Writes HI/LO
        cls_move,                                         // Reads HI/LO
        cls_none                                          // Dropped
    } op_class_t;

    typedef enum logic [1:0] {
        md_idle,
        md_divide,
        md_fixup
    } md_state_t;

endpackage

`default_nettype wire
